// ==== flist.f ====
+incdir+source
+incdir+dv
source/video_pkg.sv
source/raster_timing.sv
source/video_addrgen.sv
source/video_fetch.sv
source/video_render.sv
source/zx_video_top.sv
dv/video_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the video testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	--top-module video_tb -f flist.f -o video_sim

# tee keeps the log even when the simulation stops on an error
./obj_dir/video_sim 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "Verification passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation finished cleanly"

// ==== dv/video_model.svh ====
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

// 16-bit galois lfsr, one step
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// one lfsr step for each bit taken
function automatic int unsigned take_bits(input int count);
	int unsigned val;
	val = 0;
	repeat (count)
	begin
		val = (val << 1) | 32'(lfsr_state[0]);
		lfsr_state = lfsr_next(lfsr_state);
	end
	return val;
endfunction

// raster position of a cycle count since reset release
function automatic int hpos_of(input longint cyc);
	return int'(cyc % `VID_HTOTAL);
endfunction

function automatic int vpos_of(input longint cyc);
	return int'((cyc / `VID_HTOTAL) % `VID_VTOTAL);
endfunction

// flash phase from the frame number
function automatic logic flash_phase(input longint cyc);
	longint frame;
	frame = cyc / (`VID_HTOTAL * `VID_VTOTAL);
	return frame[`VID_FLASH_LOG2];
endfunction

function automatic logic in_window(input int pos, input int start, input int len);
	return (pos >= start) && (pos < start + len);
endfunction

// zx screen layout for fetch counter g
function automatic dram_addr_t zx_addr(input fetch_ctr_t g, input logic page);
	logic [11:0] low;
	if (g[0])
		low = {3'b110, g[12:8], g[4:1]};
	else
		low = {g[12:11], g[7:5], g[10:8], g[4:1]};
	return {6'b000001, page, 2'b10, low};
endfunction

// expected colour of pixel x on pixel line y
function automatic zx_color_t pixel_color(input int x, input int y, input logic page,
	input logic phase, output logic flashing);
	dram_addr_t pix_a;
	dram_addr_t attr_a;
	dram_word_t pw;
	dram_word_t aw;
	logic [7:0] pb;
	logic [7:0] ab;
	logic       ink;
	// pixel word then attribute word of this 16-pixel column
	pix_a  = zx_addr(fetch_ctr_t'(y * `VID_LINE_WORDS + (x / 16) * 2), page);
	attr_a = zx_addr(fetch_ctr_t'(y * `VID_LINE_WORDS + (x / 16) * 2 + 1), page);
	pw     = vmem[{page, pix_a[11:0]}];
	aw     = vmem[{page, attr_a[11:0]}];
	// high byte for the left half, msb first
	pb       = (x % 16 < 8) ? pw[15:8] : pw[7:0];
	ab       = (x % 16 < 8) ? aw[15:8] : aw[7:0];
	ink      = pb[7 - x % 8] ^ (ab[7] & phase);
	flashing = ab[7];
	return {ab[6], ink ? ab[2:0] : ab[5:3]};
endfunction

task automatic check_value(input string name, input logic [31:0] got,
	input logic [31:0] expected);
	if (got !== expected)
	begin
		$display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
		abort_run();
	end
endtask

`endif

// ==== dv/video_tb.sv ====
`default_nettype none

`include "video_config.svh"

module video_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import video_pkg::*;

	localparam int     FRAME_CYCLES = `VID_HTOTAL * `VID_VTOTAL;
	localparam int     RUN_FRAMES   = 18;
	localparam longint RUN_CYCLES   = longint'(RUN_FRAMES) * FRAME_CYCLES;
	// whole run plus 100 clocks of margin at 8 ns each
	localparam longint WATCHDOG_NS  = (RUN_CYCLES + 100) * 8;

	logic       clk;
	logic       arst_n;
	logic       scr_page;
	logic [2:0] border;
	dram_addr_t video_addr;
	logic       video_req;
	logic       video_next;
	dram_word_t video_data;
	logic       video_strobe;
	zx_color_t  color;
	logic       hsync;
	logic       vsync;

	// arbiter memory indexed by page bit and 12 address bits
	dram_word_t  vmem [0:8191];
	logic [15:0] lfsr_state;
	// reads in flight with the oldest first
	longint      ret_due [$];
	dram_word_t  ret_data [$];

	zx_video_top dut0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.scr_page     (scr_page),
		.border       (border),
		.video_addr   (video_addr),
		.video_req    (video_req),
		.video_next   (video_next),
		.video_data   (video_data),
		.video_strobe (video_strobe),
		.color        (color),
		.hsync        (hsync),
		.vsync        (vsync)
	);

	always #4 clk = ~clk;

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "simulation stopped after an error");
	endtask

	`include "video_model.svh"

	// watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		abort_run();
	end

	initial
	begin
		longint     n;
		longint     p;
		longint     last_due;
		int         i;
		int         h;
		int         v;
		int         hp;
		int         vp;
		int         gap_left;
		int         line_grants;
		int         flash_cnt [0:1];
		fetch_ctr_t k_model;
		logic       page_frame;
		logic       phase;
		logic       flashing;
		logic [2:0] bd1;
		logic [2:0] bd2;
		dram_addr_t got_addr;
		zx_color_t  exp_color;

		clk          = 1'b0;
		arst_n       = 1'b1;
		video_next   = 1'b0;
		video_strobe = 1'b0;
		video_data   = '0;
		lfsr_state   = 16'd41744;
		for (i = 0; i < 8192; i++)
			vmem[i] = dram_word_t'(take_bits(16));
		border       = 3'(take_bits(3));
		scr_page     = 1'(take_bits(1));
		last_due     = -1;
		gap_left     = 0;
		line_grants  = 0;
		flash_cnt[0] = 0;
		flash_cnt[1] = 0;
		k_model      = '0;
		page_frame   = scr_page;
		bd1          = border;

		#1 arst_n = 1'b0;
		repeat (16) @(posedge clk);
		// reset values
		check_value("video_req", video_req, 0);
		check_value("color", color, 0);
		check_value("hsync", hsync, 0);
		check_value("vsync", vsync, 0);
		#1 arst_n = 1'b1;

		// one pass per clock 1 ns after the edge at raster position n
		for (n = 0; n < RUN_CYCLES; n++)
		begin
			h   = hpos_of(n);
			v   = vpos_of(n);
			// border seen at n-1 and n-2
			bd2 = bd1;
			bd1 = border;
			if (h == 0 && v == 0)
			begin
				k_model    = '0;
				page_frame = scr_page;
			end
			if (h == 0)
				line_grants = 0;

			// outputs lag the raster by two clocks
			if (n >= 2)
			begin
				p  = n - 2;
				hp = hpos_of(p);
				vp = vpos_of(p);
				if (in_window(hp, `VID_HPIX_START, `VID_HPIX_LEN) &&
					in_window(vp, `VID_VPIX_START, `VID_VPIX_LEN))
				begin
					phase     = flash_phase(p);
					exp_color = pixel_color(hp - `VID_HPIX_START, vp - `VID_VPIX_START,
						page_frame, phase, flashing);
					if (flashing)
						flash_cnt[phase] = flash_cnt[phase] + 1;
				end
				else
					exp_color = {1'b0, bd2};
				check_value("color", color, exp_color);
				check_value("hsync", hsync, in_window(hp, `VID_HSYNC_START, `VID_HSYNC_LEN));
				check_value("vsync", vsync, in_window(vp, `VID_VSYNC_START, `VID_VSYNC_LEN));
			end

			// request window from line start to the 32nd grant
			check_value("video_req", video_req,
				in_window(v, `VID_VPIX_START, `VID_VPIX_LEN) && h != 0 &&
				line_grants < `VID_LINE_WORDS);

			// data return in grant order
			video_strobe = 1'b0;
			video_data   = '0;
			if (ret_due.size() > 0 && ret_due[0] <= n)
			begin
				video_strobe = 1'b1;
				video_data   = ret_data.pop_front();
				void'(ret_due.pop_front());
			end

			// grants one or two idle clocks apart
			video_next = 1'b0;
			if (gap_left > 0)
				gap_left = gap_left - 1;
			else if (video_req)
			begin
				video_next = 1'b1;
				got_addr   = video_addr;
				check_value("video_addr", got_addr, zx_addr(k_model, page_frame));
				k_model     = k_model + 1'b1;
				line_grants = line_grants + 1;
				// latency 1 to 3 and never two strobes in one clock
				p        = n + longint'(take_bits(2) % 3) + 1;
				last_due = (p > last_due) ? p : last_due + 1;
				ret_due.push_back(last_due);
				ret_data.push_back(vmem[{got_addr[14], got_addr[11:0]}]);
				gap_left = int'(take_bits(1)) + 1;
			end

			// new border and page on the line after vsync
			if (h == 0 && v == `VID_VSYNC_START + `VID_VSYNC_LEN)
			begin
				border   = 3'(take_bits(3));
				scr_page = 1'(take_bits(1));
			end

			@(posedge clk);
			#1;
		end

		// flashing cells seen in both phases
		check_value("flash pixels in phase 0", flash_cnt[0] != 0, 1);
		check_value("flash pixels in phase 1", flash_cnt[1] != 0, 1);
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/zx_video_top.sv ====
`default_nettype none

module zx_video_top (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   scr_page,
	input  wire logic [2:0]       border,
	output video_pkg::dram_addr_t video_addr,
	output logic                  video_req,
	input  wire                   video_next,
	input  wire video_pkg::dram_word_t video_data,
	input  wire                   video_strobe,
	output video_pkg::zx_color_t  color,
	output logic                  hsync,
	output logic                  vsync
);
	import video_pkg::*;

	// raster events
	wire            line_start;
	wire            int_start;
	wire            vpix;
	wire            hpix;
	wire            hsync_raw;
	wire            vsync_raw;
	// line-buffer writes
	wire            lb_we;
	wire line_idx_t  lb_idx;
	wire dram_word_t lb_data;

	raster_timing u_raster (
		.clk        (clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.int_start  (int_start),
		.vpix       (vpix),
		.hpix       (hpix),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw)
	);

	// address for the arbiter
	video_addrgen u_addrgen (
		.clk        (clk),
		.arst_n     (arst_n),
		.int_start  (int_start),
		.video_next (video_next),
		.scr_page   (scr_page),
		.video_addr (video_addr)
	);

	video_fetch u_fetch (
		.clk          (clk),
		.arst_n       (arst_n),
		.line_start   (line_start),
		.vpix         (vpix),
		.video_next   (video_next),
		.video_strobe (video_strobe),
		.video_data   (video_data),
		.video_req    (video_req),
		.lb_we        (lb_we),
		.lb_idx       (lb_idx),
		.lb_data      (lb_data)
	);

	video_render u_render (
		.clk       (clk),
		.arst_n    (arst_n),
		.int_start (int_start),
		.vpix      (vpix),
		.hpix      (hpix),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw),
		.border    (border),
		.lb_we     (lb_we),
		.lb_idx    (lb_idx),
		.lb_data   (lb_data),
		.color     (color),
		.hsync     (hsync),
		.vsync     (vsync)
	);

endmodule

`default_nettype wire

// ==== source/video_render.sv ====
`default_nettype none

`include "video_config.svh"

module video_render (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   int_start,
	input  wire                   vpix,
	input  wire                   hpix,
	input  wire                   hsync_raw,
	input  wire                   vsync_raw,
	input  wire logic [2:0]       border,
	input  wire                   lb_we,
	input  wire video_pkg::line_idx_t  lb_idx,
	input  wire video_pkg::dram_word_t lb_data,
	output video_pkg::zx_color_t  color,
	output logic                  hsync,
	output logic                  vsync
);
	import video_pkg::*;

	// one line of pixel and attribute words, interleaved
	dram_word_t line_buf [0:`VID_LINE_WORDS-1];

	// pixel x within the window
	logic [7:0] px_cnt;
	line_idx_t  rd_pix_idx;
	line_idx_t  rd_attr_idx;

	// frame count for flash
	logic [`VID_FLASH_LOG2:0] frame_cnt;
	logic                     flash;

	// stage one
	logic       s1_area;
	logic       s1_hsync;
	logic       s1_vsync;
	logic [3:0] s1_x;
	logic [2:0] s1_border;
	dram_word_t s1_pix;
	dram_word_t s1_attr;

	// stage two decode
	logic [7:0] pix_byte;
	logic [7:0] attr_byte;
	logic       pix_bit;
	logic       ink_sel;
	zx_color_t  color_nxt;

	// writes from the fetch side
	always_ff @(posedge clk)
	begin
		if (lb_we)
			line_buf[lb_idx] <= lb_data;
	end

	// zero on the first hpix cycle since it idles at zero outside
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			px_cnt <= '0;
		else if (!hpix)
			px_cnt <= '0;
		else
			px_cnt <= px_cnt + 1'b1;
	end

	// 16 pixels per word pair
	assign rd_pix_idx  = {px_cnt[7:4], 1'b0};
	assign rd_attr_idx = {px_cnt[7:4], 1'b1};

	// starts at all ones, first int_start brings frame 0
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			frame_cnt <= '1;
		else if (int_start)
			frame_cnt <= frame_cnt + 1'b1;
	end

	assign flash = frame_cnt[`VID_FLASH_LOG2];

	// stage one control
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s1_area  <= 1'b0;
			s1_hsync <= 1'b0;
			s1_vsync <= 1'b0;
		end
		else
		begin
			s1_area  <= hpix & vpix;
			s1_hsync <= hsync_raw;
			s1_vsync <= vsync_raw;
		end
	end

	// stage one buffer read
	always_ff @(posedge clk)
	begin
		s1_pix    <= line_buf[rd_pix_idx];
		s1_attr   <= line_buf[rd_attr_idx];
		s1_x      <= px_cnt[3:0];
		s1_border <= border;
	end

	// high byte first, msb first
	always_comb
	begin
		pix_byte  = s1_x[3] ? s1_pix[7:0] : s1_pix[15:8];
		attr_byte = s1_x[3] ? s1_attr[7:0] : s1_attr[15:8];
		pix_bit   = pix_byte[3'd7 - s1_x[2:0]];
		// flash swaps ink and paper
		ink_sel   = pix_bit ^ (attr_byte[7] & flash);
		if (s1_area)
			color_nxt = {attr_byte[6], ink_sel ? attr_byte[2:0] : attr_byte[5:3]};
		else
			color_nxt = {1'b0, s1_border};
	end

	// stage two
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			color <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else
		begin
			color <= color_nxt;
			hsync <= s1_hsync;
			vsync <= s1_vsync;
		end
	end

endmodule

`default_nettype wire

// ==== source/video_fetch.sv ====
`default_nettype none

`include "video_config.svh"

module video_fetch (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   line_start,
	input  wire                   vpix,
	input  wire                   video_next,
	input  wire                   video_strobe,
	input  wire video_pkg::dram_word_t video_data,
	output logic                  video_req,
	output logic                  lb_we,
	output video_pkg::line_idx_t  lb_idx,
	output video_pkg::dram_word_t lb_data
);
	import video_pkg::*;

	// grants taken on this line
	line_idx_t grant_cnt;
	// words returned on this line
	line_idx_t ret_cnt;
	logic      grant;
	logic      last_grant;

	assign grant      = video_req & video_next;
	assign last_grant = grant && (grant_cnt == line_idx_t'(`VID_LINE_WORDS - 1));

	// request window opens at line start on pixel lines only
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			video_req <= 1'b0;
		else if (line_start)
			video_req <= vpix;
		else if (last_grant)
			video_req <= 1'b0;
	end

	// grant count shapes the window
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			grant_cnt <= '0;
		else if (line_start)
			grant_cnt <= '0;
		else if (grant)
			grant_cnt <= grant_cnt + 1'b1;
	end

	// return count is separate, several words may be in flight
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ret_cnt <= '0;
		else if (line_start)
			ret_cnt <= '0;
		else if (video_strobe)
			ret_cnt <= ret_cnt + 1'b1;
	end

	// data lands in order of the grants
	assign lb_we   = video_strobe;
	assign lb_idx  = ret_cnt;
	assign lb_data = video_data;

endmodule

`default_nettype wire

// ==== source/video_addrgen.sv ====
`default_nettype none

module video_addrgen (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   int_start,
	input  wire                   video_next,
	input  wire                   scr_page,
	output video_pkg::dram_addr_t video_addr
);
	import video_pkg::*;

	// frame-wide word counter
	fetch_ctr_t  gctr;
	logic        frame_init_r;
	logic        ld_addr;
	logic [11:0] addr_pix;
	logic [11:0] addr_attr;
	dram_addr_t  addr_zx;

	// one cycle after frame start, preload the first address
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			frame_init_r <= 1'b0;
		else
			frame_init_r <= int_start;
	end

	// grant or frame preload
	assign ld_addr = video_next | frame_init_r;

	// cleared per frame, stepped on every load
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			gctr <= '0;
		else if (int_start)
			gctr <= '0;
		else if (ld_addr)
			gctr <= gctr + 1'b1;
	end

	// zx pixel layout, thirds and char rows interleaved
	assign addr_pix  = {gctr[12:11], gctr[7:5], gctr[10:8], gctr[4:1]};
	// attributes follow the pixels at 0x1800
	assign addr_attr = {3'b110, gctr[12:8], gctr[4:1]};

	// page select sits just above the screen area
	assign addr_zx = {6'b000001, scr_page, 2'b10, gctr[0] ? addr_attr : addr_pix};

	// holds the next word to fetch
	always_ff @(posedge clk)
	begin
		if (ld_addr)
			video_addr <= addr_zx;
	end

endmodule

`default_nettype wire

// ==== source/raster_timing.sv ====
`default_nettype none

`include "video_config.svh"

module raster_timing (
	input  wire  clk,
	input  wire  arst_n,
	output logic line_start,
	output logic int_start,
	output logic vpix,
	output logic hpix,
	output logic hsync_raw,
	output logic vsync_raw
);
	import video_pkg::*;

	// current raster position
	hcount_t hcount;
	vcount_t vcount;
	// position one cycle ahead
	hcount_t hcount_nxt;
	vcount_t vcount_nxt;
	logic    h_last;
	logic    v_last;

	assign h_last = (hcount == hcount_t'(`VID_HTOTAL - 1));
	assign v_last = (vcount == vcount_t'(`VID_VTOTAL - 1));

	// wrap at the config totals
	always_comb
	begin
		hcount_nxt = h_last ? '0 : hcount + 1'b1;
		vcount_nxt = vcount;
		if (h_last)
			vcount_nxt = v_last ? '0 : vcount + 1'b1;
	end

	// levels come from the next position so they line up with the counters
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hcount    <= '0;
			vcount    <= '0;
			hpix      <= 1'b0;
			vpix      <= 1'b0;
			hsync_raw <= 1'b0;
			vsync_raw <= 1'b0;
		end
		else
		begin
			hcount    <= hcount_nxt;
			vcount    <= vcount_nxt;
			hpix      <= (hcount_nxt >= hcount_t'(`VID_HPIX_START)) &&
				(hcount_nxt < hcount_t'(`VID_HPIX_START + `VID_HPIX_LEN));
			vpix      <= (vcount_nxt >= vcount_t'(`VID_VPIX_START)) &&
				(vcount_nxt < vcount_t'(`VID_VPIX_START + `VID_VPIX_LEN));
			hsync_raw <= (hcount_nxt >= hcount_t'(`VID_HSYNC_START)) &&
				(hcount_nxt < hcount_t'(`VID_HSYNC_START + `VID_HSYNC_LEN));
			vsync_raw <= (vcount_nxt >= vcount_t'(`VID_VSYNC_START)) &&
				(vcount_nxt < vcount_t'(`VID_VSYNC_START + `VID_VSYNC_LEN));
		end
	end

	// pulses straight off the counters
	assign line_start = (hcount == '0);
	assign int_start  = line_start && (vcount == '0);

endmodule

`default_nettype wire

// ==== source/video_pkg.sv ====
`default_nettype none

package video_pkg;

	// dram side
	typedef logic [20:0] dram_addr_t;
	typedef logic [15:0] dram_word_t;

	// frame-wide fetch counter
	// bit 0 attribute, 4..1 word in line, 12..5 pixel line
	typedef logic [12:0] fetch_ctr_t;

	// raster position
	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;

	// bright, green, red, blue
	typedef logic [3:0] zx_color_t;
	typedef logic [4:0] line_idx_t;
endpackage

`default_nettype wire

// ==== source/video_config.svh ====
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// raster geometry in clocks per line and lines per frame
`define VID_HTOTAL 448
`define VID_VTOTAL 320

// horizontal pixel window
`define VID_HPIX_START 128
`define VID_HPIX_LEN 256

// vertical pixel window
`define VID_VPIX_START 64
`define VID_VPIX_LEN 192

// sync placement and length
`define VID_HSYNC_START 400
`define VID_HSYNC_LEN 32
`define VID_VSYNC_START 300
`define VID_VSYNC_LEN 4

// pixel and attribute words per pixel line
`define VID_LINE_WORDS 32

// flash phase is this bit of the frame count
`define VID_FLASH_LOG2 4

`endif
